// File: core_defs.svh
// widths are fixed for the 16-bit ISA; changing them needs new instruction field slicing too
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define CORE_XLEN 16     // data word width, also the address width
`define CORE_NREGS 8     // register count, register 0 is hard zero
`define CORE_ILEN 16     // one instruction per instruction memory word
`define CORE_RESET_PC 0  // first fetch address after reset

`endif

// File: core_pkg.sv
// opcodes outside op_t are folded into op_halt by decode, so this list is the whole ISA
`include "core_defs.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;            // one data word or word address
    typedef logic [$clog2(`CORE_NREGS)-1:0] reg_t;    // register index

    // encodings match bits 15..12 of the instruction word
    typedef enum logic [3:0] {
        op_add  = 4'h0,
        op_sub  = 4'h1,
        op_and  = 4'h2,
        op_xor  = 4'h3,
        op_addi = 4'h4,
        op_ld   = 4'h5,
        op_st   = 4'h6,
        op_beq  = 4'h7,
        op_halt = 4'hf
    } op_t;

    // where decode takes an operand from
    typedef enum logic [1:0] {
        fwd_regfile,  // register array, no hazard in flight
        fwd_execute,  // result computed this cycle in execute
        fwd_memory,   // non-load result held in the memory stage
        fwd_load      // prdata of a load finishing this cycle
    } fwd_t;

    typedef struct packed {
        word_t                  pc;    // address the instruction came from
        logic [`CORE_ILEN-1:0]  inst;  // raw instruction word
    } id_t;

    typedef struct packed {
        op_t   op;
        word_t pc;       // needed for the branch target
        word_t a;        // rs1 value
        word_t b;        // rs2 value, or rd value for st and beq
        word_t st_data;  // value written by st
        word_t imm;      // sign-extended imm6
    } ex_t;

    typedef struct packed {
        op_t   op;
        word_t result;   // alu value, or the address for ld and st
        word_t st_data;
    } mm_t;

endpackage

// File: cpu.sv
// apb slave must not rely on pslverr; instruction memory is a combinational read port
`include "core_defs.svh"

module cpu
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    output word_t                 imem_addr,
    input  logic [`CORE_ILEN-1:0] imem_data,
    output word_t                 paddr,
    output logic                  psel,
    output logic                  penable,
    output logic                  pwrite,
    output word_t                 pwdata,
    input  word_t                 prdata,
    input  logic                  pready,
    output logic                  halted
);

    stage_if #(.payload_t(id_t)) id ();  // fetch to decode
    stage_if #(.payload_t(ex_t)) ex ();  // decode to execute
    stage_if #(.payload_t(mm_t)) mm ();  // execute to memory

    logic  stall;
    logic  flush;
    fwd_t  rs1_sel;
    fwd_t  rs2_sel;
    reg_t  rs1;
    reg_t  rs2;
    logic  branch;
    word_t target;
    word_t alu_data;
    word_t exe_data;
    word_t mem_data;
    logic  rd_en_wb;
    reg_t  rd_wb;
    word_t rd_data_wb;

    hazard_ctrl i_hazard_ctrl (
        .id(id.monitor),
        .ex(ex.monitor),
        .mm(mm.monitor),
        .rs1, .rs2, .branch,
        .stall, .flush, .rs1_sel, .rs2_sel
    );

    fetch i_fetch (
        .clk, .arst_n, .stall, .flush, .branch, .target, .halted,
        .imem_addr, .imem_data,
        .down(id.up)
    );

    decode i_decode (
        .clk, .arst_n, .stall, .flush, .rs1_sel, .rs2_sel,
        .alu_data, .exe_data, .mem_data,
        .rd_en_wb, .rd_wb, .rd_data_wb,
        .rs1, .rs2,
        .up(id.down),
        .down(ex.up)
    );

    execute i_execute (
        .clk, .arst_n, .alu_data, .branch, .target,
        .up(ex.down),
        .down(mm.up)
    );

    memory_apb i_memory_apb (
        .clk, .arst_n,
        .paddr, .pwdata, .psel, .penable, .pwrite, .prdata, .pready,
        .mem_data, .exe_data, .rd_en_wb, .rd_wb, .rd_data_wb, .halted,
        .up(mm.down)
    );

endmodule

// File: cpu_asserts.sv
// apb and reset checks for the cpu top level; addresses are assumed held by the memory stage
module cpu_asserts
    import core_pkg::*;
(
    input logic  clk,
    input logic  arst_n,
    input logic  psel,
    input logic  penable,
    input logic  pwrite,
    input word_t paddr,
    input word_t pwdata,
    input logic  halted
);

    // a transfer always opens with its setup phase
    assert property (@(posedge clk) disable iff (!arst_n) $rose(psel) |-> !penable)
        else $error("psel rose together with penable");

    assert property (@(posedge clk) disable iff (!arst_n) penable |-> psel)
        else $error("penable high without psel");

    assert property (@(posedge clk) disable iff (!arst_n) psel && !penable |=> psel && penable)
        else $error("setup phase not followed by an access phase");

    // address, data and direction stay put from setup to the end of the access
    assert property (@(posedge clk) disable iff (!arst_n)
        penable |-> $stable(paddr) && $stable(pwdata) && $stable(pwrite))
        else $error("apb address or data changed inside a transfer");

    assert property (@(posedge clk) disable iff (!arst_n) halted |=> halted)
        else $error("halted dropped before reset");

    assert property (@(posedge clk) !arst_n |-> !psel && !penable && !halted)
        else $error("apb or halted active during reset");

endmodule

// File: cpu_patterns.txt
# tag address data, all hex
# I instruction word, M initial data word, W expected store in order
I 00 4205
I 01 4443
I 02 0650
I 03 18c8
I 04 3b18
I 05 6a18
I 06 6641
I 07 5c10
I 08 5e11
I 09 23f0
I 0a 6219
I 0b 5410
I 0c 641a
I 0d 7242
I 0e 681b
I 0f 6a1c
I 10 7282
I 11 681d
I 12 4007
I 13 601e
I 14 f000
I 15 6a1f
M 10 1234
M 11 0f0f
W 0018 0005
W 0006 000d
W 0019 0204
W 001a 1234
W 001d 0008
W 001e 0000

// File: cpu_tb.sv
// memories are 256 words deep, so program and data addresses must stay below 8'hff
module cpu_tb
    import core_pkg::*;
;

    logic        clk;
    logic        arst_n;
    word_t       imem_addr;
    logic [15:0] imem_data;
    word_t       paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    word_t       pwdata;
    word_t       prdata;
    logic        pready;
    logic        halted;

    word_t       imem [0:255];  // program, unused words decode as halt
    word_t       dmem [0:255];  // data memory behind the apb slave
    word_t       exp_addr [$];  // expected store addresses in order
    word_t       exp_data [$];
    int          store_cnt;
    int          wait_left;     // wait states left in the current access

    cpu i_cpu (.*);

    bind cpu cpu_asserts i_cpu_asserts (
        .clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .halted(halted)
    );

    always #5 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            fail_run("value mismatch");
        end
    endtask

    // tagged lines, I and M fill memories, W queues an expected store
    task automatic load_patterns();
        int    fd;
        int    code;
        string tag;
        string line;
        word_t a;
        word_t d;
        fd = $fopen("cpu_patterns.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open cpu_patterns.txt");
        end
        code = $fscanf(fd, " %s", tag);
        while (code == 1) begin
            if (tag == "#") begin
                code = $fgets(line, fd);  // rest of a comment line
            end else begin
                code = $fscanf(fd, " %h %h", a, d);
                case (tag)
                    "I": imem[a[7:0]] = d;
                    "M": dmem[a[7:0]] = d;
                    "W": begin
                        exp_addr.push_back(a);
                        exp_data.push_back(d);
                    end
                    default: fail_run("unknown tag in cpu_patterns.txt");
                endcase
            end
            code = $fscanf(fd, " %s", tag);
        end
        $fclose(fd);
    endtask

    task automatic record_store();
        if (store_cnt >= exp_addr.size()) begin
            fail_run("store seen beyond the expected sequence");
        end
        check_value("paddr", paddr, exp_addr[store_cnt]);
        check_value("pwdata", pwdata, exp_data[store_cnt]);
        dmem[paddr[7:0]] = pwdata;
        store_cnt++;
    endtask

    // instruction port and apb slave, both driven on the falling edge
    always @(negedge clk) begin
        imem_data <= imem[imem_addr[7:0]];  // address only moves on the rising edge
        if (arst_n) begin
            if (psel && halted) begin
                fail_run("apb transfer started after halt");
            end
            if (psel && !penable) begin
                wait_left = $urandom % 4;  // 0 to 3 wait states
                pready <= 1'b0;
            end else if (psel && penable) begin
                if (wait_left == 0) begin
                    pready <= 1'b1;
                    if (pwrite) begin
                        record_store();
                    end else begin
                        prdata <= dmem[paddr[7:0]];
                    end
                end else begin
                    wait_left--;
                    pready <= 1'b0;
                end
            end else begin
                pready <= 1'b0;
            end
        end
    end

    initial begin
        int cycles;
        void'($urandom(32'h71f6));
        clk       = 1'b0;
        arst_n    = 1'b0;
        imem_data = '0;
        prdata    = '0;
        pready    = 1'b0;
        store_cnt = 0;
        wait_left = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = {8'hf0, i[7:0]};   // halt opcode with the address in the low byte
            dmem[i] = {i[7:0], ~i[7:0]};
        end
        load_patterns();
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_value("psel", word_t'(psel), '0);
            check_value("penable", word_t'(penable), '0);
            check_value("halted", word_t'(halted), '0);
            check_value("imem_addr", imem_addr, '0);
        end
        arst_n = 1'b1;
        cycles = 0;
        while (!halted && cycles < 2000) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            fail_run("timeout waiting for halted");
        end
        repeat (20) begin
            @(negedge clk);  // the slave block flags any transfer here
        end
        check_value("store_count", word_t'(store_cnt), word_t'(exp_addr.size()));
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: decode.sv
// register 0 reads as zero and ignores writes; unknown opcodes decode as halt
`include "core_defs.svh"

module decode
    import core_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    stall,
    input  logic    flush,
    input  fwd_t    rs1_sel,
    input  fwd_t    rs2_sel,
    input  word_t   alu_data,
    input  word_t   exe_data,
    input  word_t   mem_data,
    input  logic    rd_en_wb,
    input  reg_t    rd_wb,
    input  word_t   rd_data_wb,
    output reg_t    rs1,
    output reg_t    rs2,
    stage_if.down   up,
    stage_if.up     down
);

    word_t regs [0:`CORE_NREGS-1];  // register array, entry 0 never written
    logic [`CORE_ILEN-1:0] inst;
    op_t   op;
    word_t imm;
    word_t opnd1;
    word_t opnd2;

    // pick one operand from the array or from a bypass
    function automatic word_t operand(input reg_t idx, input fwd_t sel);
        word_t value;
        case (sel)
            fwd_execute: value = alu_data;
            fwd_memory:  value = exe_data;
            fwd_load:    value = mem_data;
            default:     value = (idx == '0) ? '0 : regs[idx];
        endcase
        return value;
    endfunction

    assign inst = up.payload.inst;
    assign imm  = {{(`CORE_XLEN-6){inst[5]}}, inst[5:0]};  // signed imm6

    always_comb begin
        case (op_t'(inst[15:12]))
            op_add, op_sub, op_and, op_xor, op_addi,
            op_ld, op_st, op_beq: op = op_t'(inst[15:12]);
            default:              op = op_halt;           // illegal opcodes stop the core
        endcase
    end

    // source registers as the hazard logic needs them
    always_comb begin
        rs1 = (op == op_halt) ? '0 : inst[8:6];
        case (op)
            op_add, op_sub, op_and, op_xor: rs2 = inst[5:3];
            op_st, op_beq:                  rs2 = inst[11:9];  // st data and beq compare use rd
            default:                        rs2 = '0;          // imm forms read no second reg
        endcase
    end

    // bypass values and the register array are read inside operand
    always_comb begin
        opnd1 = operand(rs1, rs1_sel);
        opnd2 = operand(rs2, rs2_sel);
    end

    // the instruction stays in place while a load-use stall inserts a bubble
    assign up.ready = down.ready && !stall;

    always_ff @(posedge clk) begin
        if (rd_en_wb && rd_wb != '0) begin
            regs[rd_wb] <= rd_data_wb;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            down.valid <= 1'b0;
        end else if (down.ready) begin
            down.valid <= up.valid && !stall && !flush;  // bubble on stall or branch
        end
    end

    always_ff @(posedge clk) begin
        if (down.ready) begin
            down.payload <= '{op: op, pc: up.payload.pc, a: opnd1, b: opnd2,
                              st_data: opnd2, imm: imm};
            down.rd      <= up.rd;                       // destination was predecoded in fetch
            down.rd_en   <= up.rd_en;
            down.is_load <= up.is_load;
        end
    end

endmodule

// File: execute.sv
// branch is only valid in the cycle the beq moves on; target counts whole instructions
module execute
    import core_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    output word_t   alu_data,
    output logic    branch,
    output word_t   target,
    stage_if.down   up,
    stage_if.up     down
);

    ex_t ex;

    assign ex       = up.payload;
    assign up.ready = down.ready;   // holds whenever the memory stage holds

    always_comb begin
        case (ex.op)
            op_add:                alu_data = ex.a + ex.b;
            op_sub:                alu_data = ex.a - ex.b;
            op_and:                alu_data = ex.a & ex.b;
            op_xor:                alu_data = ex.a ^ ex.b;
            op_addi, op_ld, op_st: alu_data = ex.a + ex.imm;  // immediate add, also the address
            default:               alu_data = '0;
        endcase
    end

    assign target = ex.pc + 1'b1 + ex.imm;                     // pc plus 1 plus imm
    assign branch = up.valid && up.ready && (ex.op == op_beq) && (ex.a == ex.b);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            down.valid <= 1'b0;
        end else if (down.ready) begin
            down.valid <= up.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (down.ready) begin
            down.payload <= '{op: ex.op, result: alu_data, st_data: ex.st_data};
            down.rd      <= up.rd;
            down.rd_en   <= up.rd_en;
            down.is_load <= up.is_load;
        end
    end

endmodule

// File: fetch.sv
// instruction memory must return imem_data for imem_addr within the same cycle
`include "core_defs.svh"

module fetch
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  branch,
    input  word_t                 target,
    input  logic                  halted,
    output word_t                 imem_addr,
    input  logic [`CORE_ILEN-1:0] imem_data,
    stage_if.up                   down
);

    word_t pc;
    logic  advance;
    op_t   opcode;

    assign imem_addr = pc;                          // address leaves straight from the pc
    assign advance   = down.ready && !stall;        // whole pipe moves in lock-step
    assign opcode    = op_t'(imem_data[15:12]);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc         <= `CORE_RESET_PC;
            down.valid <= 1'b0;
        end else if (branch) begin
            pc <= target;                           // redirect, the word on imem_data is dropped
            if (flush) begin
                down.valid <= 1'b0;
            end
        end else if (halted) begin
            down.valid <= 1'b0;                     // core stopped, pc frozen
        end else if (advance) begin
            pc         <= pc + 1'b1;                // pc counts instructions, not bytes
            down.valid <= 1'b1;
        end
    end

    // predecode the destination so hazard_ctrl sees it one stage early
    always_ff @(posedge clk) begin
        if (advance) begin
            down.payload <= '{pc: pc, inst: imem_data};
            down.rd      <= imem_data[11:9];
            down.rd_en   <= opcode inside {op_add, op_sub, op_and, op_xor, op_addi, op_ld};
            down.is_load <= (opcode == op_ld);
        end
    end

endmodule

// File: files.f
+incdir+.
core_pkg.sv
stage_if.sv
fetch.sv
decode.sv
execute.sv
memory_apb.sv
hazard_ctrl.sv
cpu.sv
cpu_asserts.sv
cpu_tb.sv

// File: hazard_ctrl.sv
// a load in execute always costs one stall; register 0 never takes a bypass
module hazard_ctrl
    import core_pkg::*;
(
    stage_if.monitor id,
    stage_if.monitor ex,
    stage_if.monitor mm,
    input  reg_t     rs1,
    input  reg_t     rs2,
    input  logic     branch,
    output logic     stall,
    output logic     flush,
    output fwd_t     rs1_sel,
    output fwd_t     rs2_sel
);

    logic ex_load_hit;

    // priority is youngest producer first
    function automatic fwd_t pick(input reg_t rs);
        fwd_t sel;
        sel = fwd_regfile;
        if (rs == '0) begin
            sel = fwd_regfile;
        end else if (ex.valid && ex.rd_en && !ex.is_load && ex.rd == rs) begin
            sel = fwd_execute;
        end else if (mm.valid && mm.rd_en && mm.rd == rs) begin
            if (!mm.is_load) begin
                sel = fwd_memory;
            end else if (mm.ready) begin
                sel = fwd_load;  // prdata valid only as the access completes
            end
        end
        return sel;
    endfunction

    assign ex_load_hit = ex.valid && ex.is_load && ex.rd_en && ex.rd != '0 &&
                         (ex.rd == rs1 || ex.rd == rs2);

    assign stall   = id.valid && ex_load_hit;  // load data is not there before the memory stage
    assign flush   = branch;                   // drops the two younger instructions

    // the stage monitors are read inside pick
    always_comb begin
        rs1_sel = pick(rs1);
        rs2_sel = pick(rs2);
    end

endmodule

// File: memory_apb.sv
// pslverr is not sampled; every transfer is a full word and a faulting slave goes unseen
module memory_apb
    import core_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    output word_t   paddr,
    output word_t   pwdata,
    output logic    psel,
    output logic    penable,
    output logic    pwrite,
    input  word_t   prdata,
    input  logic    pready,
    output word_t   mem_data,
    output word_t   exe_data,
    output logic    rd_en_wb,
    output reg_t    rd_wb,
    output word_t   rd_data_wb,
    output logic    halted,
    stage_if.down   up
);

    typedef enum logic [1:0] {
        apb_idle,
        apb_setup,
        apb_access
    } apb_state_t;

    mm_t        mm;
    apb_state_t state_q;  // only ever holds idle or access
    apb_state_t state;    // setup is the first cycle of a request, seen from the payload
    logic       mem_req;
    logic       done;
    logic       retire;

    assign mm      = up.payload;
    assign mem_req = up.valid && (mm.op inside {op_ld, op_st}) && !halted;

    always_comb begin
        if (state_q == apb_access) begin
            state = apb_access;
        end else if (mem_req) begin
            state = apb_setup;
        end else begin
            state = apb_idle;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= apb_idle;
        end else begin
            case (state)
                apb_setup:  state_q <= apb_access;
                apb_access: state_q <= pready ? apb_idle : apb_access;  // wait states stay here
                default:    state_q <= apb_idle;
            endcase
        end
    end

    assign psel    = (state != apb_idle);
    assign penable = (state == apb_access);
    assign pwrite  = (mm.op == op_st);
    assign paddr   = mm.result;       // held by the upstream register until ready
    assign pwdata  = mm.st_data;

    assign done     = penable && pready;
    assign up.ready = !mem_req || done;  // back-pressure only from an open transfer
    assign retire   = up.valid && up.ready && !halted;

    assign mem_data   = prdata;          // load bypass, meaningful only with done
    assign exe_data   = mm.result;       // memory stage bypass for alu results
    assign rd_en_wb   = retire && up.rd_en;
    assign rd_wb      = up.rd;
    assign rd_data_wb = up.is_load ? prdata : mm.result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted <= 1'b0;
        end else if (retire && mm.op == op_halt) begin
            halted <= 1'b1;  // sticky until reset, items behind it are dropped
        end
    end

endmodule

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module cpu_tb -o cpu_sim \
    && ./obj_dir/cpu_sim | tee /dev/stderr | grep -q "NO ERRORS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: stage_if.sv
// rd, rd_en and is_load ride beside the payload so hazard logic never decodes payload types
interface stage_if
    import core_pkg::*;
#(
    parameter type payload_t = logic
) ();

    logic     valid;    // producer has an item
    logic     ready;    // consumer takes it this cycle
    payload_t payload;  // stage specific content
    reg_t     rd;       // destination register of the item
    logic     rd_en;    // item writes rd
    logic     is_load;  // item is a ld, its data only appears in the memory stage

    modport up (output valid, payload, rd, rd_en, is_load, input ready);

    modport down (input valid, payload, rd, rd_en, is_load, output ready);

    modport monitor (input valid, ready, payload, rd, rd_en, is_load);

endinterface
